/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_peripheral_subsystem -f list.f
	./obj_dir/Vtb_peripheral_subsystem > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* gpio_block.sv */
`timescale 1ns/10ps
/* GPIO registers: output, output enable, synchronized input,
   rising-edge interrupt enable and write-one-to-clear status */
module gpio_block (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  logic              wr_en_i,
  input  logic              rd_en_i,
  input  periph_pkg::offs_t offs_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::gpio_t gpio_i,
  output periph_pkg::data_t rdata_o,
  output periph_pkg::gpio_t gpio_o,
  output periph_pkg::gpio_t gpio_en_o,
  output periph_pkg::gpio_t intr_o
);

  periph_pkg::gpio_t out_q;
  periph_pkg::gpio_t oe_q;
  periph_pkg::gpio_t ie_q;
  periph_pkg::gpio_t is_q;
  periph_pkg::gpio_t meta_q;
  periph_pkg::gpio_t in_sync_q;
  periph_pkg::gpio_t in_prev_q;

  periph_pkg::gpio_t wr_bits;
  periph_pkg::gpio_t rise;
  logic              wr;

  assign wr = sel_i & wr_en_i;
  assign wr_bits = wdata_i[periph_pkg::NUM_GPIO-1:0];
  assign rise = in_sync_q & ~in_prev_q & ie_q;

  assign gpio_o = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o = is_q;

  // Two-stage synchronizer plus one stage for edge detection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      meta_q <= gpio_i;
      in_sync_q <= meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q <= '0;
      ie_q <= '0;
      is_q <= '0;
    end else begin
      if (wr && offs_i == periph_pkg::GPIO_OUT_OFFS) begin
        out_q <= wr_bits;
      end
      if (wr && offs_i == periph_pkg::GPIO_OE_OFFS) begin
        oe_q <= wr_bits;
      end
      if (wr && offs_i == periph_pkg::GPIO_IE_OFFS) begin
        ie_q <= wr_bits;
      end
      // A new edge wins over a clear in the same cycle
      if (wr && offs_i == periph_pkg::GPIO_IS_OFFS) begin
        is_q <= (is_q & ~wr_bits) | rise;
      end else begin
        is_q <= is_q | rise;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (sel_i && rd_en_i) begin
      case (offs_i)
        periph_pkg::GPIO_IN_OFFS:  rdata_o = periph_pkg::data_t'(in_sync_q);
        periph_pkg::GPIO_OUT_OFFS: rdata_o = periph_pkg::data_t'(out_q);
        periph_pkg::GPIO_OE_OFFS:  rdata_o = periph_pkg::data_t'(oe_q);
        periph_pkg::GPIO_IE_OFFS:  rdata_o = periph_pkg::data_t'(ie_q);
        periph_pkg::GPIO_IS_OFFS:  rdata_o = periph_pkg::data_t'(is_q);
        default:                   rdata_o = '0;
      endcase
    end
  end

endmodule

/* irq_ctrl.sv */
`timescale 1ns/10ps
/* Interrupt controller: level-latched pending bits, enable mask,
   lowest-ID claim and software interrupt bit */
module irq_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  logic              wr_en_i,
  input  logic              rd_en_i,
  input  periph_pkg::offs_t offs_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::src_t  src_i,
  output periph_pkg::data_t rdata_o,
  output logic              irq_o,
  output logic              msip_o
);

  periph_pkg::src_t    pend_q;
  periph_pkg::src_t    en_q;
  logic                msip_q;
  logic                irq_q;

  periph_pkg::src_t    active;
  periph_pkg::src_t    clr_mask;
  periph_pkg::src_id_t claim_id;
  logic                wr;
  logic                claim;

  assign wr = sel_i & wr_en_i;
  assign claim = sel_i & rd_en_i & (offs_i == periph_pkg::IRQ_CLAIM_OFFS);
  assign active = pend_q & en_q;

  assign irq_o = irq_q;
  assign msip_o = msip_q;

  // Lowest active ID, source 0 never claimed
  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = periph_pkg::src_id_t'(i);
      end
    end
  end

  always_comb begin
    clr_mask = '0;
    if (claim) begin
      clr_mask[claim_id] = 1'b1;
    end
  end

  // Clear wins, a source still high sets its bit again next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
      en_q <= '0;
      msip_q <= 1'b0;
      irq_q <= 1'b0;
    end else begin
      pend_q <= (pend_q | src_i) & ~clr_mask;
      irq_q <= |active;
      if (wr && offs_i == periph_pkg::IRQ_EN_OFFS) begin
        en_q <= wdata_i[periph_pkg::NUM_SRC-1:0];
      end
      if (wr && offs_i == periph_pkg::IRQ_MSIP_OFFS) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (sel_i && rd_en_i) begin
      case (offs_i)
        periph_pkg::IRQ_PEND_OFFS:  rdata_o = periph_pkg::data_t'(pend_q);
        periph_pkg::IRQ_EN_OFFS:    rdata_o = periph_pkg::data_t'(en_q);
        periph_pkg::IRQ_CLAIM_OFFS: rdata_o = periph_pkg::data_t'(claim_id);
        periph_pkg::IRQ_MSIP_OFFS:  rdata_o = periph_pkg::data_t'(msip_q);
        default:                    rdata_o = '0;
      endcase
    end
  end

endmodule

/* list.f */
periph_pkg.sv
periph_bus_ctrl.sv
gpio_block.sv
irq_ctrl.sv
peripheral_subsystem.sv
peripheral_subsystem_properties.sv
tb_peripheral_subsystem.sv

/* periph_bus_ctrl.sv */
`timescale 1ns/10ps
/* Bus slave control: request/grant handshake, address decode,
   internal target strobes, external window and response return */
module periph_bus_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::data_t gpio_rdata_i,
  input  periph_pkg::data_t irq_rdata_i,
  input  logic              ext_ready_i,
  input  periph_pkg::data_t ext_rdata_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output periph_pkg::data_t rdata_o,
  output logic              err_o,
  output logic              wr_en_o,
  output logic              rd_en_o,
  output periph_pkg::offs_t offs_o,
  output periph_pkg::data_t wdata_o,
  output logic              gpio_sel_o,
  output logic              irq_sel_o,
  output logic              ext_req_o,
  output logic              ext_we_o,
  output periph_pkg::offs_t ext_addr_o,
  output periph_pkg::data_t ext_wdata_o
);

  periph_pkg::bus_state_e state_q;
  periph_pkg::bus_state_e state_d;
  periph_pkg::data_t      rdata_q;
  logic                   err_q;
  logic                   ext_we_q;
  periph_pkg::offs_t      ext_addr_q;
  periph_pkg::data_t      ext_wdata_q;

  logic accept;
  logic gpio_hit;
  logic irq_hit;
  logic ext_hit;

  assign gpio_hit = (addr_i & periph_pkg::REGION_MASK) == periph_pkg::GPIO_BASE;
  assign irq_hit = (addr_i & periph_pkg::REGION_MASK) == periph_pkg::IRQ_BASE;
  assign ext_hit = (addr_i & periph_pkg::REGION_MASK) == periph_pkg::EXT_BASE;

  assign gnt_o = (state_q == periph_pkg::BUS_IDLE);
  assign accept = req_i & gnt_o;

  // Strobes only in the grant cycle
  assign gpio_sel_o = accept & gpio_hit;
  assign irq_sel_o = accept & irq_hit;
  assign wr_en_o = (gpio_sel_o | irq_sel_o) & we_i;
  assign rd_en_o = (gpio_sel_o | irq_sel_o) & ~we_i;
  assign offs_o = addr_i[periph_pkg::OFFS_W-1:0];
  assign wdata_o = wdata_i;

  assign rvalid_o = (state_q == periph_pkg::BUS_RESP);
  assign rdata_o = rdata_q;
  assign err_o = err_q;

  assign ext_req_o = (state_q == periph_pkg::BUS_EXT);
  assign ext_we_o = ext_we_q;
  assign ext_addr_o = ext_addr_q;
  assign ext_wdata_o = ext_wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_pkg::BUS_IDLE: begin
        if (accept) begin
          state_d = ext_hit ? periph_pkg::BUS_EXT : periph_pkg::BUS_RESP;
        end
      end
      periph_pkg::BUS_EXT: begin
        if (ext_ready_i) begin
          state_d = periph_pkg::BUS_RESP;
        end
      end
      default: state_d = periph_pkg::BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Targets drive zero unless read-strobed, so OR picks the one answering
  always_ff @(posedge clk_i) begin
    if (accept) begin
      err_q <= ~(gpio_hit | irq_hit | ext_hit);
      rdata_q <= gpio_rdata_i | irq_rdata_i;
      if (ext_hit) begin
        ext_we_q <= we_i;
        ext_addr_q <= addr_i[periph_pkg::OFFS_W-1:0];
        ext_wdata_q <= wdata_i;
      end
    end else if (ext_req_o && ext_ready_i) begin
      rdata_q <= ext_we_q ? '0 : ext_rdata_i;
    end
  end

endmodule

/* periph_pkg.sv */
/* Shared widths, address map, register offsets, interrupt source
   numbering and the bus controller state type */
package periph_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int OFFS_W = 8;

  localparam int NUM_GPIO = 8;
  localparam int NUM_EXT_INT = 4;
  localparam int NUM_SRC = 16;
  localparam int SRC_ID_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [OFFS_W-1:0] offs_t;
  typedef logic [NUM_GPIO-1:0] gpio_t;
  typedef logic [NUM_SRC-1:0] src_t;
  typedef logic [SRC_ID_W-1:0] src_id_t;

  // Source 0 is reserved, sources above the external lines are tied off
  localparam int GPIO_SRC_BASE = 1;
  localparam int EXT_SRC_BASE = 9;

  // Each region spans 256 bytes
  localparam addr_t REGION_MASK = 32'hFFFF_FF00;
  localparam addr_t GPIO_BASE = 32'h0000_0000;
  localparam addr_t IRQ_BASE = 32'h0000_0100;
  localparam addr_t EXT_BASE = 32'h0000_0200;

  localparam offs_t GPIO_IN_OFFS = 8'h00;
  localparam offs_t GPIO_OUT_OFFS = 8'h04;
  localparam offs_t GPIO_OE_OFFS = 8'h08;
  localparam offs_t GPIO_IE_OFFS = 8'h0C;
  localparam offs_t GPIO_IS_OFFS = 8'h10;

  localparam offs_t IRQ_PEND_OFFS = 8'h00;
  localparam offs_t IRQ_EN_OFFS = 8'h04;
  localparam offs_t IRQ_CLAIM_OFFS = 8'h08;
  localparam offs_t IRQ_MSIP_OFFS = 8'h0C;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_EXT,
    BUS_RESP
  } bus_state_e;

endpackage

/* peripheral_subsystem.sv */
`timescale 1ns/10ps
/* Peripheral subsystem top: bus controller, GPIO block, interrupt
   controller and the interrupt source vector */
module peripheral_subsystem (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  periph_pkg::addr_t                  addr_i,
  input  periph_pkg::data_t                  wdata_i,
  input  periph_pkg::gpio_t                  gpio_i,
  input  logic [periph_pkg::NUM_EXT_INT-1:0] ext_intr_i,
  input  logic                               ext_ready_i,
  input  periph_pkg::data_t                  ext_rdata_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output periph_pkg::data_t                  rdata_o,
  output logic                               err_o,
  output periph_pkg::gpio_t                  gpio_o,
  output periph_pkg::gpio_t                  gpio_en_o,
  output logic                               irq_o,
  output logic                               msip_o,
  output logic                               ext_req_o,
  output logic                               ext_we_o,
  output periph_pkg::offs_t                  ext_addr_o,
  output periph_pkg::data_t                  ext_wdata_o
);

  logic              wr_en;
  logic              rd_en;
  logic              gpio_sel;
  logic              irq_sel;
  periph_pkg::offs_t offs;
  periph_pkg::data_t wdata;
  periph_pkg::data_t gpio_rdata;
  periph_pkg::data_t irq_rdata;
  periph_pkg::gpio_t gpio_intr;
  periph_pkg::src_t  intr_src;

  // Source 0 reserved, unused upper IDs tied low
  assign intr_src[0] = 1'b0;
  assign intr_src[periph_pkg::GPIO_SRC_BASE +: periph_pkg::NUM_GPIO] = gpio_intr;
  assign intr_src[periph_pkg::EXT_SRC_BASE +: periph_pkg::NUM_EXT_INT] = ext_intr_i;
  assign intr_src[periph_pkg::NUM_SRC-1:periph_pkg::EXT_SRC_BASE+periph_pkg::NUM_EXT_INT] = '0;

  periph_bus_ctrl bus_ctrl_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .gpio_rdata_i (gpio_rdata),
    .irq_rdata_i  (irq_rdata),
    .ext_ready_i  (ext_ready_i),
    .ext_rdata_i  (ext_rdata_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o),
    .wr_en_o      (wr_en),
    .rd_en_o      (rd_en),
    .offs_o       (offs),
    .wdata_o      (wdata),
    .gpio_sel_o   (gpio_sel),
    .irq_sel_o    (irq_sel),
    .ext_req_o    (ext_req_o),
    .ext_we_o     (ext_we_o),
    .ext_addr_o   (ext_addr_o),
    .ext_wdata_o  (ext_wdata_o)
  );

  gpio_block gpio_block_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .sel_i     (gpio_sel),
    .wr_en_i   (wr_en),
    .rd_en_i   (rd_en),
    .offs_i    (offs),
    .wdata_i   (wdata),
    .gpio_i    (gpio_i),
    .rdata_o   (gpio_rdata),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  irq_ctrl irq_ctrl_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sel_i   (irq_sel),
    .wr_en_i (wr_en),
    .rd_en_i (rd_en),
    .offs_i  (offs),
    .wdata_i (wdata),
    .src_i   (intr_src),
    .rdata_o (irq_rdata),
    .irq_o   (irq_o),
    .msip_o  (msip_o)
  );

endmodule

/* peripheral_subsystem_properties.sv */
`timescale 1ns/10ps
/* Concurrent assertions on the bus handshake, the external window
   and the interrupt output */
module peripheral_subsystem_properties (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              req_i,
  input logic              gnt_i,
  input logic              rvalid_i,
  input logic              ext_req_i,
  input logic              ext_ready_i,
  input logic              ext_we_i,
  input periph_pkg::offs_t ext_addr_i,
  input periph_pkg::data_t ext_wdata_i,
  input logic              irq_i,
  input periph_pkg::src_t  pend_i,
  input periph_pkg::src_t  en_i
);

  // High between an accepted transfer and its response
  logic outstanding_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (req_i && gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  gnt_rvalid_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(gnt_i && rvalid_i)) else $error("gnt_o and rvalid_o high in the same cycle");

  no_grant_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && gnt_i) |-> !outstanding_q) else $error("grant while a response is due");

  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding_q) else $error("rvalid_o without an accepted transfer");

  rvalid_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |=> !rvalid_i) else $error("rvalid_o longer than one cycle");

  ext_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ext_req_i && !ext_ready_i) |=> (ext_req_i && $stable(ext_we_i) &&
    $stable(ext_addr_i) && $stable(ext_wdata_i)))
    else $error("external request changed before ext_ready_i");

  irq_falls: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(|(pend_i & en_i)) |=> !irq_i) else $error("irq_o high with nothing enabled pending");

endmodule

/* tb_peripheral_subsystem.sv */
`timescale 1ns/10ps
/* Testbench for the peripheral subsystem: clock, reset, bus tasks,
   external responder, directed tests, compare tasks and watchdog */
module tb_peripheral_subsystem;

  localparam int NUM_TESTS = 6;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     req;
  logic                     we;
  periph_pkg::addr_t        addr;
  periph_pkg::data_t        wdata;
  periph_pkg::gpio_t        gpio_in;
  logic [periph_pkg::NUM_EXT_INT-1:0] ext_intr;
  logic                     ext_ready;
  periph_pkg::data_t        ext_rdata;
  logic                     gnt;
  logic                     rvalid;
  periph_pkg::data_t        rdata;
  logic                     err;
  periph_pkg::gpio_t        gpio_out;
  periph_pkg::gpio_t        gpio_en;
  logic                     irq;
  logic                     msip;
  logic                     ext_req;
  logic                     ext_we;
  periph_pkg::offs_t        ext_addr;
  periph_pkg::data_t        ext_wdata;

  int                errors;
  int                checks;
  int                tests_run;
  int                errors_at_start;
  string             test_name;
  logic [31:0]       lfsr_state;
  int                ext_req_count;
  periph_pkg::offs_t last_wr_offs;
  periph_pkg::data_t last_wr_data;

  always #2 clk = ~clk;

  peripheral_subsystem dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .gpio_i      (gpio_in),
    .ext_intr_i  (ext_intr),
    .ext_ready_i (ext_ready),
    .ext_rdata_i (ext_rdata),
    .gnt_o       (gnt),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .err_o       (err),
    .gpio_o      (gpio_out),
    .gpio_en_o   (gpio_en),
    .irq_o       (irq),
    .msip_o      (msip),
    .ext_req_o   (ext_req),
    .ext_we_o    (ext_we),
    .ext_addr_o  (ext_addr),
    .ext_wdata_o (ext_wdata)
  );

  bind peripheral_subsystem peripheral_subsystem_properties props_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .gnt_i       (gnt_o),
    .rvalid_i    (rvalid_o),
    .ext_req_i   (ext_req_o),
    .ext_ready_i (ext_ready_i),
    .ext_we_i    (ext_we_o),
    .ext_addr_i  (ext_addr_o),
    .ext_wdata_i (ext_wdata_o),
    .irq_i       (irq_o),
    .pend_i      (irq_ctrl_i.pend_q),
    .en_i        (irq_ctrl_i.en_q)
  );

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic periph_pkg::data_t ext_read_value(input periph_pkg::offs_t o);
    return {16'hC0DE, o, ~o};
  endfunction

  function automatic periph_pkg::addr_t reg_addr(input periph_pkg::addr_t base,
                                                 input periph_pkg::offs_t o);
    return base | periph_pkg::addr_t'(o);
  endfunction

  // External target model with a ready delay of 0 to 3 cycles
  initial begin : ext_responder
    int delay;
    ext_ready = 1'b0;
    ext_rdata = '0;
    ext_req_count = 0;
    last_wr_offs = '0;
    last_wr_data = '0;
    lfsr_state = 32'h56ea_f43e;
    forever begin
      @(negedge clk);
      if (ext_req) begin
        ext_req_count++;
        if (ext_we) begin
          last_wr_offs = ext_addr;
          last_wr_data = ext_wdata;
        end
        delay = 0;
        for (int b = 0; b < 2; b++) begin
          delay = delay * 2 + int'(next_rand_bit());
        end
        repeat (delay) @(posedge clk);
        @(posedge clk);
        ext_ready <= 1'b1;
        ext_rdata <= ext_read_value(ext_addr);
        @(posedge clk);
        ext_ready <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * 2000);
    $display("timeout: the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  task automatic check_data(input string name, input periph_pkg::data_t got,
                            input periph_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input periph_pkg::gpio_t got,
                            input periph_pkg::gpio_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    checks++;
    errors++;
    $display("%0s", msg);
  endtask

  // One transfer drives the request, waits for grant and then for the response
  task automatic bus_access(input logic is_write, input periph_pkg::addr_t a,
                            input periph_pkg::data_t d, output periph_pkg::data_t r,
                            output logic e);
    @(posedge clk);
    req <= 1'b1;
    we <= is_write;
    addr <= a;
    wdata <= d;
    @(negedge clk);
    while (!gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (!rvalid) begin
      @(negedge clk);
    end
    r = rdata;
    e = err;
  endtask

  task automatic bus_write(input periph_pkg::addr_t a, input periph_pkg::data_t d,
                           input logic exp_err);
    periph_pkg::data_t r;
    logic              e;
    bus_access(1'b1, a, d, r, e);
    check_data("rdata_o", r, '0);
    check_bit("err_o", e, exp_err);
  endtask

  task automatic bus_read(input periph_pkg::addr_t a, output periph_pkg::data_t r,
                          output logic e);
    bus_access(1'b0, a, '0, r, e);
  endtask

  task automatic read_and_check(input periph_pkg::addr_t a, input periph_pkg::data_t exp,
                                input string name);
    periph_pkg::data_t r;
    logic              e;
    bus_read(a, r, e);
    check_data(name, r, exp);
    check_bit("err_o", e, 1'b0);
  endtask

  task automatic wait_irq_level(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      report_failure("irq_o did not reach the expected level in time");
    end else begin
      checks++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      $display("test %0s: ok", test_name);
    end else begin
      $display("test %0s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic reset_state_test();
    begin_test("reset_state");
    @(negedge clk);
    check_bit("gnt_o", gnt, 1'b1);
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("irq_o", irq, 1'b0);
    check_bit("msip_o", msip, 1'b0);
    check_bit("ext_req_o", ext_req, 1'b0);
    check_gpio("gpio_o", gpio_out, '0);
    check_gpio("gpio_en_o", gpio_en, '0);
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OUT_OFFS), '0, "gpio out");
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE_OFFS), '0, "gpio oe");
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IE_OFFS), '0, "gpio ie");
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IS_OFFS), '0, "gpio is");
    end_test();
  endtask

  task automatic gpio_reg_test();
    begin_test("gpio_regs");
    bus_write(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OUT_OFFS), 32'h1234_56A5, 1'b0);
    check_gpio("gpio_o", gpio_out, 8'hA5);
    bus_write(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE_OFFS), 32'h0000_003C, 1'b0);
    check_gpio("gpio_en_o", gpio_en, 8'h3C);
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OUT_OFFS), 32'hA5, "gpio out");
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE_OFFS), 32'h3C, "gpio oe");
    @(posedge clk);
    gpio_in <= 8'h5A;
    repeat (3) @(posedge clk);
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IN_OFFS), 32'h5A, "gpio in");
    end_test();
  endtask

  // Pins 0 and 2 rise but only pin 0 of them is enabled
  task automatic gpio_irq_test();
    begin_test("gpio_irq");
    @(posedge clk);
    gpio_in <= '0;
    repeat (4) @(posedge clk);
    bus_write(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IE_OFFS), 32'h0000_0003, 1'b0);
    @(posedge clk);
    gpio_in <= 8'h05;
    repeat (4) @(posedge clk);
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IS_OFFS), 32'h01, "gpio is");
    bus_write(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IS_OFFS), 32'h0000_0001, 1'b0);
    read_and_check(reg_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IS_OFFS), '0, "gpio is");
    end_test();
  endtask

  // Source 1 is still pending from GPIO pin 0 and stays disabled here
  task automatic irq_ctrl_test();
    periph_pkg::data_t exp_pend;
    periph_pkg::data_t en_val;
    begin_test("irq_ctrl");
    exp_pend = '0;
    exp_pend[periph_pkg::GPIO_SRC_BASE] = 1'b1;
    exp_pend[periph_pkg::EXT_SRC_BASE] = 1'b1;
    exp_pend[periph_pkg::EXT_SRC_BASE + 2] = 1'b1;
    en_val = '0;
    en_val[periph_pkg::EXT_SRC_BASE] = 1'b1;
    en_val[periph_pkg::EXT_SRC_BASE + 2] = 1'b1;
    en_val[periph_pkg::EXT_SRC_BASE + 3] = 1'b1;
    @(posedge clk);
    ext_intr <= 4'b0101;
    repeat (2) @(posedge clk);
    ext_intr <= '0;
    read_and_check(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_PEND_OFFS), exp_pend, "pending");
    check_bit("irq_o", irq, 1'b0);
    bus_write(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_EN_OFFS), en_val, 1'b0);
    wait_irq_level(1'b1, 8);
    read_and_check(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_CLAIM_OFFS),
                   periph_pkg::data_t'(periph_pkg::EXT_SRC_BASE), "claim");
    read_and_check(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_CLAIM_OFFS),
                   periph_pkg::data_t'(periph_pkg::EXT_SRC_BASE + 2), "claim");
    read_and_check(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_CLAIM_OFFS), '0, "claim");
    wait_irq_level(1'b0, 8);
    exp_pend = '0;
    exp_pend[periph_pkg::GPIO_SRC_BASE] = 1'b1;
    read_and_check(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_PEND_OFFS), exp_pend, "pending");
    bus_write(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_MSIP_OFFS), 32'h1, 1'b0);
    check_bit("msip_o", msip, 1'b1);
    bus_write(reg_addr(periph_pkg::IRQ_BASE, periph_pkg::IRQ_MSIP_OFFS), 32'h0, 1'b0);
    check_bit("msip_o", msip, 1'b0);
    end_test();
  endtask

  task automatic ext_window_test();
    periph_pkg::offs_t o;
    int                start_count;
    begin_test("ext_window");
    start_count = ext_req_count;
    bus_write(reg_addr(periph_pkg::EXT_BASE, 8'h10), 32'hDEAD_BEEF, 1'b0);
    check_data("ext_addr_o", periph_pkg::data_t'(last_wr_offs), 32'h10);
    check_data("ext_wdata_o", last_wr_data, 32'hDEAD_BEEF);
    bus_write(reg_addr(periph_pkg::EXT_BASE, 8'hFC), 32'h0BAD_F00D, 1'b0);
    check_data("ext_addr_o", periph_pkg::data_t'(last_wr_offs), 32'hFC);
    check_data("ext_wdata_o", last_wr_data, 32'h0BAD_F00D);
    for (int k = 0; k < 8; k++) begin
      o = periph_pkg::offs_t'(k * 12);
      read_and_check(reg_addr(periph_pkg::EXT_BASE, o), ext_read_value(o), "ext rdata");
    end
    if (ext_req_count != start_count + 10) begin
      report_failure("the external window saw the wrong number of requests");
    end
    end_test();
  endtask

  task automatic unmapped_test();
    periph_pkg::data_t r;
    logic              e;
    int                start_count;
    begin_test("unmapped");
    start_count = ext_req_count;
    bus_read(32'h0000_0400, r, e);
    check_bit("err_o", e, 1'b1);
    check_data("rdata_o", r, '0);
    bus_write(32'h0001_0000, 32'hFFFF_FFFF, 1'b1);
    bus_read(32'hFFFF_FF00, r, e);
    check_bit("err_o", e, 1'b1);
    check_data("rdata_o", r, '0);
    if (ext_req_count != start_count) begin
      report_failure("an unmapped access started an external request");
    end
    end_test();
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    gpio_in = '0;
    ext_intr = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    errors_at_start = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_state_test();
    gpio_reg_test();
    gpio_irq_test();
    irq_ctrl_test();
    ext_window_test();
    unmapped_test();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
